// File: ext_irq.f
hw/ext_irq_pkg.sv
hw/wb_decode.sv
hw/ext_int.sv
hw/irq_ctrl.sv
hw/ext_irq_top.sv
verification/ext_irq_tb.sv

// File: hw/ext_int.sv
`timescale 1ns/1ps

module ext_int
	import ext_irq_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	// bus slave
	input  logic [DATA_WIDTH-1:0]  sa_dat_i,
	input  ext_reg_e               sa_addr_i,
	input  logic                   sa_stb_i,
	input  logic                   sa_we_i,
	output logic [DATA_WIDTH-1:0]  sa_dat_o,
	output logic                   sa_ack_o,
	// pins in, status out to irq_ctrl
	input  logic [EXT_INT_NUM-1:0] ext_int_i,
	output logic [EXT_INT_NUM-1:0] ext_int_o
);

	logic                   ger;
	logic [EXT_INT_NUM-1:0] ier_rise;
	logic [EXT_INT_NUM-1:0] ier_fall;
	logic [EXT_INT_NUM-1:0] isr;
	logic [EXT_INT_NUM-1:0] int_reg1;	// latest pin sample
	logic [EXT_INT_NUM-1:0] int_reg2;	// previous sample
	logic [EXT_INT_NUM-1:0] rise_edge;
	logic [EXT_INT_NUM-1:0] fall_edge;
	logic [EXT_INT_NUM-1:0] triggered;
	logic [EXT_INT_NUM-1:0] wr_bits;
	logic [EXT_INT_NUM-1:0] isr_clr;
	logic                   access;
	logic                   wr_en;
	logic                   rd_en;
	logic [DATA_WIDTH-1:0]  rd_data;
	logic [DATA_WIDTH-1:0]  rd_next;

	// one access per strobe, the ack cycle itself is not a new access
	assign access = sa_stb_i && !sa_ack_o;
	assign wr_en  = access && sa_we_i;
	assign rd_en  = access && !sa_we_i;

	assign wr_bits = sa_dat_i[EXT_INT_NUM-1:0];

	assign rise_edge = ger ? (ier_rise & ~int_reg2 & int_reg1) : '0;
	assign fall_edge = ger ? (ier_fall & int_reg2 & ~int_reg1) : '0;
	assign triggered = rise_edge | fall_edge;

	assign isr_clr = (wr_en && sa_addr_i == ISR) ? wr_bits : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			int_reg1 <= '0;
			int_reg2 <= '0;
			ger      <= 1'b0;
			ier_rise <= '0;
			ier_fall <= '0;
			isr      <= '0;
			sa_ack_o <= 1'b0;
		end else begin
			int_reg1 <= ext_int_i;
			int_reg2 <= int_reg1;
			// a new edge wins over a clear of the same bit
			isr      <= (isr & ~isr_clr) | triggered;
			sa_ack_o <= access;
			if (wr_en) begin
				case (sa_addr_i)
					GER:      ger      <= sa_dat_i[0];
					IER_RISE: ier_rise <= wr_bits;
					IER_FALL: ier_fall <= wr_bits;
					default: ;	// ISR handled above, PIN read only
				endcase
			end
		end
	end

	always_comb begin
		case (sa_addr_i)
			GER:      rd_next = DATA_WIDTH'(ger);
			IER_RISE: rd_next = DATA_WIDTH'(ier_rise);
			IER_FALL: rd_next = DATA_WIDTH'(ier_fall);
			ISR:      rd_next = DATA_WIDTH'(isr);
			PIN:      rd_next = DATA_WIDTH'(ext_int_i);	// live levels, not the sampled copy
			default:  rd_next = '0;
		endcase
	end

	// read data captured at the ack edge
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= rd_next;
		end
	end

	assign sa_dat_o  = rd_data;
	assign ext_int_o = isr;

endmodule

// File: hw/ext_irq_pkg.sv
package ext_irq_pkg;

	// pin count, one status bit per pin
	localparam int EXT_INT_NUM = 8;

	// bus geometry
	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 4;	// word address
	localparam int SEL_WIDTH  = 4;	// byte selects, registers are written whole

	// source id, log2 of pin count
	localparam int ID_WIDTH = 3;

	// address bit 3 picks the window: 0-7 ext_int, 8-15 irq_ctrl
	localparam int WINDOW_BIT = 3;

	// ext_int register offsets
	typedef enum logic [WINDOW_BIT-1:0] {
		GER      = 3'd0,	// global enable, bit 0
		IER_RISE = 3'd1,	// rising edge enables
		IER_FALL = 3'd2,	// falling edge enables
		ISR      = 3'd3,	// sticky status, write 1 to clear
		PIN      = 3'd4	// raw pin levels, read only
	} ext_reg_e;

	// irq_ctrl register offsets
	typedef enum logic [WINDOW_BIT-1:0] {
		MASK = 3'd0,	// read/write
		PEND = 3'd1,	// status & mask
		ID   = 3'd2	// bit 31 valid, low bits lowest pending index
	} irq_reg_e;

	// highest mapped offset per window, anything above is a hole
	localparam ext_reg_e EXT_LAST = PIN;
	localparam irq_reg_e IRQ_LAST = ID;

	// ID register layout
	localparam int ID_VALID_BIT = DATA_WIDTH - 1;

endpackage

// File: hw/ext_irq_top.sv
`timescale 1ns/1ps

module ext_irq_top
	import ext_irq_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	// bus slave port
	input  logic [ADDR_WIDTH-1:0]  addr_i,
	input  logic [DATA_WIDTH-1:0]  dat_i,
	input  logic [SEL_WIDTH-1:0]   sel_i,	// byte lanes not decoded
	input  logic                   stb_i,
	input  logic                   we_i,
	output logic [DATA_WIDTH-1:0]  dat_o,
	output logic                   ack_o,
	// pins and processor interrupt
	input  logic [EXT_INT_NUM-1:0] ext_int_i,
	output logic                   irq_o,
	output logic [ID_WIDTH-1:0]    irq_id_o
);

	logic                   ext_stb;
	logic                   ext_ack;
	logic [DATA_WIDTH-1:0]  ext_dat;
	logic                   irq_stb;
	logic                   irq_ack;
	logic [DATA_WIDTH-1:0]  irq_dat;
	logic [EXT_INT_NUM-1:0] isr;
	ext_reg_e               ext_offs;
	irq_reg_e               irq_offs;

	// low address bits are the register offset in either window
	assign ext_offs = ext_reg_e'(addr_i[WINDOW_BIT-1:0]);
	assign irq_offs = irq_reg_e'(addr_i[WINDOW_BIT-1:0]);

	wb_decode i_wb_decode (
		.clk       (clk),
		.reset     (reset),
		.addr_i    (addr_i),
		.stb_i     (stb_i),
		.ack_o     (ack_o),
		.dat_o     (dat_o),
		.ext_stb_o (ext_stb),
		.ext_ack_i (ext_ack),
		.ext_dat_i (ext_dat),
		.irq_stb_o (irq_stb),
		.irq_ack_i (irq_ack),
		.irq_dat_i (irq_dat)
	);

	ext_int i_ext_int (
		.clk       (clk),
		.reset     (reset),
		.sa_dat_i  (dat_i),
		.sa_addr_i (ext_offs),
		.sa_stb_i  (ext_stb),
		.sa_we_i   (we_i),
		.sa_dat_o  (ext_dat),
		.sa_ack_o  (ext_ack),
		.ext_int_i (ext_int_i),
		.ext_int_o (isr)
	);

	irq_ctrl i_irq_ctrl (
		.clk       (clk),
		.reset     (reset),
		.sa_dat_i  (dat_i),
		.sa_addr_i (irq_offs),
		.sa_stb_i  (irq_stb),
		.sa_we_i   (we_i),
		.sa_dat_o  (irq_dat),
		.sa_ack_o  (irq_ack),
		.isr_i     (isr),
		.irq_o     (irq_o),
		.irq_id_o  (irq_id_o)
	);

endmodule

// File: hw/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl
	import ext_irq_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	// bus slave
	input  logic [DATA_WIDTH-1:0]  sa_dat_i,
	input  irq_reg_e               sa_addr_i,
	input  logic                   sa_stb_i,
	input  logic                   sa_we_i,
	output logic [DATA_WIDTH-1:0]  sa_dat_o,
	output logic                   sa_ack_o,
	// status from ext_int
	input  logic [EXT_INT_NUM-1:0] isr_i,
	// to the processor
	output logic                   irq_o,
	output logic [ID_WIDTH-1:0]    irq_id_o
);

	logic [EXT_INT_NUM-1:0] mask;
	logic [EXT_INT_NUM-1:0] pend;
	logic                   pend_any;
	logic [ID_WIDTH-1:0]    low_id;
	logic                   access;
	logic                   wr_en;
	logic                   rd_en;
	logic [DATA_WIDTH-1:0]  rd_data;
	logic [DATA_WIDTH-1:0]  rd_next;

	assign access = sa_stb_i && !sa_ack_o;
	assign wr_en  = access && sa_we_i;
	assign rd_en  = access && !sa_we_i;

	assign pend     = isr_i & mask;
	assign pend_any = |pend;

	// fixed priority, lowest index wins
	always_comb begin
		low_id = '0;
		for (int i = EXT_INT_NUM - 1; i >= 0; i--) begin
			if (pend[i]) begin
				low_id = ID_WIDTH'(i);
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mask     <= '0;
			irq_o    <= 1'b0;
			irq_id_o <= '0;
			sa_ack_o <= 1'b0;
		end else begin
			sa_ack_o <= access;
			irq_o    <= pend_any;
			if (pend_any) begin
				irq_id_o <= low_id;	// holds last id when idle
			end
			if (wr_en && sa_addr_i == MASK) begin
				mask <= sa_dat_i[EXT_INT_NUM-1:0];
			end
		end
	end

	always_comb begin
		rd_next = '0;
		case (sa_addr_i)
			MASK: rd_next = DATA_WIDTH'(mask);
			PEND: rd_next = DATA_WIDTH'(pend);
			ID: begin
				rd_next[ID_VALID_BIT]   = pend_any;
				rd_next[ID_WIDTH-1:0]   = low_id;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= rd_next;
		end
	end

	assign sa_dat_o = rd_data;

endmodule

// File: hw/wb_decode.sv
`timescale 1ns/1ps

module wb_decode
	import ext_irq_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	// master side
	input  logic [ADDR_WIDTH-1:0] addr_i,
	input  logic                  stb_i,
	output logic                  ack_o,
	output logic [DATA_WIDTH-1:0] dat_o,
	// ext_int window
	output logic                  ext_stb_o,
	input  logic                  ext_ack_i,
	input  logic [DATA_WIDTH-1:0] ext_dat_i,
	// irq_ctrl window
	output logic                  irq_stb_o,
	input  logic                  irq_ack_i,
	input  logic [DATA_WIDTH-1:0] irq_dat_i
);

	logic [WINDOW_BIT-1:0] offset;
	logic                  irq_win;
	logic                  ext_hit;
	logic                  irq_hit;
	logic                  hole;
	logic                  hole_ack;

	assign offset  = addr_i[WINDOW_BIT-1:0];
	assign irq_win = addr_i[WINDOW_BIT];

	// mapped only up to the last defined offset of each window
	assign ext_hit = !irq_win && (offset <= EXT_LAST);
	assign irq_hit = irq_win && (offset <= IRQ_LAST);
	assign hole    = !(ext_hit || irq_hit);

	assign ext_stb_o = stb_i && ext_hit;
	assign irq_stb_o = stb_i && irq_hit;

	// local one cycle ack for unmapped offsets, nothing is written
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hole_ack <= 1'b0;
		end else begin
			hole_ack <= stb_i && hole && !hole_ack;
		end
	end

	// master holds addr stable until ack, so the window bit steers the return path
	always_comb begin
		if (hole_ack) begin
			ack_o = 1'b1;
			dat_o = '0;	// holes read as zero
		end else if (irq_win) begin
			ack_o = irq_ack_i;
			dat_o = irq_dat_i;
		end else begin
			ack_o = ext_ack_i;
			dat_o = ext_dat_i;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the ext_irq testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module ext_irq_tb -f ext_irq.f \
	--Mdir obj_dir -o ext_irq_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/ext_irq_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1

// File: verification/ext_irq_tb.sv
`timescale 1ns/1ps

module ext_irq_tb
	import ext_irq_pkg::*;
();

	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 10;
	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 200;
	localparam int ACK_LIMIT       = 8;
	localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + 2 * RESET_CYCLES) * CLK_PERIOD;
	localparam logic [31:0] SEED   = 32'h673e_ed82;

	logic                   clk = 1'b0;
	logic                   reset;
	logic [ADDR_WIDTH-1:0]  addr_i;
	logic [DATA_WIDTH-1:0]  dat_i;
	logic [SEL_WIDTH-1:0]   sel_i;
	logic                   stb_i;
	logic                   we_i;
	logic [DATA_WIDTH-1:0]  dat_o;
	logic                   ack_o;
	logic [EXT_INT_NUM-1:0] ext_int_i;
	logic                   irq_o;
	logic [ID_WIDTH-1:0]    irq_id_o;

	int                     err_cnt = 0;
	int                     pass_cnt = 0;
	int                     fail_cnt = 0;
	logic [EXT_INT_NUM-1:0] pins_q;	// last value driven on the pins

	// reference model fed only from what the testbench drives
	logic [EXT_INT_NUM-1:0] samp_m = '0;
	logic [EXT_INT_NUM-1:0] samp_prev_m = '0;
	logic                   ger_m = 1'b0;
	logic [EXT_INT_NUM-1:0] rise_m = '0;
	logic [EXT_INT_NUM-1:0] fall_m = '0;
	logic [EXT_INT_NUM-1:0] mask_m = '0;
	logic [EXT_INT_NUM-1:0] isr_m = '0;
	logic                   stb_q = 1'b0;
	logic                   wr_start;
	logic [EXT_INT_NUM-1:0] clr_m;
	logic [EXT_INT_NUM-1:0] edges_m;
	logic [EXT_INT_NUM-1:0] pend_m;
	logic [ID_WIDTH-1:0]    low_m;
	logic                   pend_any_q = 1'b0;
	logic [ID_WIDTH-1:0]    low_q = '0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	ext_irq_top i_ext_irq_top (
		.clk       (clk),
		.reset     (reset),
		.addr_i    (addr_i),
		.dat_i     (dat_i),
		.sel_i     (sel_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.ext_int_i (ext_int_i),
		.irq_o     (irq_o),
		.irq_id_o  (irq_id_o)
	);

	function automatic logic [ADDR_WIDTH-1:0] ext_addr(input ext_reg_e r);
		return {1'b0, r};
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] irq_addr(input irq_reg_e r);
		return {1'b1, r};
	endfunction

	function automatic logic [ID_WIDTH-1:0] lowest_set(input logic [EXT_INT_NUM-1:0] v);
		logic [ID_WIDTH-1:0] idx;
		logic                found;
		idx   = '0;
		found = 1'b0;
		for (int i = 0; i < EXT_INT_NUM; i++) begin
			if (v[i] && !found) begin
				idx   = ID_WIDTH'(i);
				found = 1'b1;
			end
		end
		return idx;
	endfunction

	function automatic logic [31:0] id_word(input logic [EXT_INT_NUM-1:0] pm);
		logic [31:0] w;
		w = '0;
		w[DATA_WIDTH-1]  = |pm;	// valid
		w[ID_WIDTH-1:0] = lowest_set(pm);
		return w;
	endfunction

	// first edge of a strobe is the one that writes
	assign wr_start = stb_i && !stb_q && we_i;
	assign clr_m    = (wr_start && addr_i == ext_addr(ISR)) ? dat_i[EXT_INT_NUM-1:0] : '0;
	assign edges_m  = ger_m ? ((rise_m & samp_m & ~samp_prev_m) |
		(fall_m & ~samp_m & samp_prev_m)) : '0;
	assign pend_m   = isr_m & mask_m;
	assign low_m    = lowest_set(pend_m);

	always @(posedge clk) begin
		if (reset) begin
			samp_m      <= '0;
			samp_prev_m <= '0;
			ger_m       <= 1'b0;
			rise_m      <= '0;
			fall_m      <= '0;
			mask_m      <= '0;
			isr_m       <= '0;
			stb_q       <= 1'b0;
		end else begin
			samp_m      <= ext_int_i;
			samp_prev_m <= samp_m;
			stb_q       <= stb_i;
			isr_m       <= (isr_m & ~clr_m) | edges_m;	// set beats clear
			if (wr_start) begin
				if (addr_i == ext_addr(GER))
					ger_m <= dat_i[0];
				if (addr_i == ext_addr(IER_RISE))
					rise_m <= dat_i[EXT_INT_NUM-1:0];
				if (addr_i == ext_addr(IER_FALL))
					fall_m <= dat_i[EXT_INT_NUM-1:0];
				if (addr_i == irq_addr(MASK))
					mask_m <= dat_i[EXT_INT_NUM-1:0];
			end
		end
	end

	always @(posedge clk) begin
		pend_any_q <= |pend_m;
		low_q      <= low_m;
	end

	ack_after_stb: assert property (@(posedge clk) disable iff (reset)
		stb_i && !ack_o |=> ack_o)
		else begin
			err_cnt++;
			$display("error: strobe not acknowledged one edge later");
		end

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack_o |=> !ack_o)
		else begin
			err_cnt++;
			$display("error: ack held longer than one cycle");
		end

	ack_needs_stb: assert property (@(posedge clk) disable iff (reset) !stb_i |=> !ack_o)
		else begin
			err_cnt++;
			$display("error: ack without a strobe");
		end

	// irq is the masked status one edge late and two edges after a pin sample
	irq_follows: assert property (@(posedge clk) disable iff (reset) irq_o == pend_any_q)
		else begin
			err_cnt++;
			$display("mismatch irq_o: got %h expected %h", $sampled(irq_o), $sampled(pend_any_q));
		end

	id_lowest: assert property (@(posedge clk) disable iff (reset) irq_o |-> irq_id_o == low_q)
		else begin
			err_cnt++;
			$display("mismatch irq_id_o: got %h expected %h", $sampled(irq_id_o),
				$sampled(low_q));
		end

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic drive_pins(input logic [EXT_INT_NUM-1:0] v);
		@(posedge clk);
		ext_int_i <= v;
		pins_q = v;
	endtask

	task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		int waited;
		waited = 0;
		@(posedge clk);
		addr_i <= addr;
		dat_i  <= data;
		we_i   <= 1'b1;
		stb_i  <= 1'b1;
		do begin
			@(posedge clk);
			waited++;
		end while (!ack_o && waited < ACK_LIMIT);
		stb_i <= 1'b0;
		we_i  <= 1'b0;
		if (!ack_o) begin
			err_cnt++;
			$display("error: write to address %h was never acknowledged", addr);
		end
	endtask

	task automatic read_expect(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
		input string name);
		int waited;
		waited = 0;
		@(posedge clk);
		addr_i <= addr;
		we_i   <= 1'b0;
		stb_i  <= 1'b1;
		do begin
			@(posedge clk);
			waited++;
		end while (!ack_o && waited < ACK_LIMIT);
		stb_i <= 1'b0;
		if (!ack_o) begin
			err_cnt++;
			$display("error: read of address %h was never acknowledged", addr);
		end else if (dat_o !== exp) begin
			err_cnt++;
			$display("mismatch %s at %h: got %h expected %h", name, addr, dat_o, exp);
		end
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		if (err_cnt == err_start) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: failed with %0d errors", name, err_cnt - err_start);
		end
	endtask

	task automatic check_register_access();
		int          e0;
		logic [31:0] g, r, f, m;
		e0 = err_cnt;
		g  = $urandom;
		r  = $urandom;
		f  = $urandom;
		m  = $urandom;
		write_reg(ext_addr(GER), g);
		write_reg(ext_addr(IER_RISE), r);
		write_reg(ext_addr(IER_FALL), f);
		write_reg(irq_addr(MASK), m);
		read_expect(ext_addr(GER), 32'(g[0]), "GER");
		read_expect(ext_addr(IER_RISE), 32'(r[7:0]), "IER_RISE");
		read_expect(ext_addr(IER_FALL), 32'(f[7:0]), "IER_FALL");
		read_expect(irq_addr(MASK), 32'(m[7:0]), "MASK");
		for (int a = 0; a < 16; a++) begin
			if ((a > 4 && a < 8) || a > 10) begin	// holes
				write_reg(4'(a), $urandom);
				read_expect(4'(a), 32'h0, "hole");
			end
		end
		read_expect(ext_addr(GER), 32'(g[0]), "GER");
		read_expect(ext_addr(IER_RISE), 32'(r[7:0]), "IER_RISE");
		read_expect(ext_addr(IER_FALL), 32'(f[7:0]), "IER_FALL");
		read_expect(irq_addr(MASK), 32'(m[7:0]), "MASK");
		report_test("register access", e0);
	endtask

	task automatic capture_edges();
		int                     e0;
		logic [EXT_INT_NUM-1:0] rise, fall, v, prev, exp;
		e0   = err_cnt;
		rise = 8'($urandom);
		fall = 8'($urandom);
		exp  = '0;
		write_reg(ext_addr(IER_RISE), 32'(rise));
		write_reg(ext_addr(IER_FALL), 32'(fall));
		write_reg(irq_addr(MASK), $urandom);
		write_reg(ext_addr(GER), 32'h1);
		write_reg(ext_addr(ISR), 32'hff);
		for (int i = 0; i < 10; i++) begin
			prev = pins_q;
			v    = 8'($urandom);
			exp  = exp | (rise & ~prev & v) | (fall & prev & ~v);
			drive_pins(v);
			idle_cycles(3);
			read_expect(ext_addr(PIN), 32'(v), "PIN");
			read_expect(ext_addr(ISR), 32'(exp), "ISR");
		end
		// with GER off toggles must leave status alone
		write_reg(ext_addr(GER), 32'h0);
		write_reg(ext_addr(ISR), 32'hff);
		for (int i = 0; i < 5; i++) begin
			drive_pins(8'($urandom));
			idle_cycles(2);
		end
		read_expect(ext_addr(ISR), 32'h0, "ISR");
		report_test("edge capture", e0);
	endtask

	task automatic clear_status();
		int                     e0;
		int                     k;
		logic [EXT_INT_NUM-1:0] v, s, c;
		e0 = err_cnt;
		write_reg(ext_addr(IER_RISE), 32'hff);
		write_reg(ext_addr(IER_FALL), 32'hff);
		write_reg(irq_addr(MASK), 32'hff);
		write_reg(ext_addr(GER), 32'h1);
		write_reg(ext_addr(ISR), 32'hff);
		v = 8'($urandom);
		s = v ^ pins_q;
		drive_pins(v);
		idle_cycles(3);
		read_expect(ext_addr(ISR), 32'(s), "ISR");
		c = 8'($urandom);
		write_reg(ext_addr(ISR), 32'(c));
		read_expect(ext_addr(ISR), 32'(s & ~c), "ISR");
		// edge lands in the cycle the clear is written
		k = $urandom % EXT_INT_NUM;
		drive_pins(pins_q ^ (8'b1 << k));
		write_reg(ext_addr(ISR), 32'hff);
		read_expect(ext_addr(ISR), 32'(8'b1 << k), "ISR");
		report_test("write-1-to-clear", e0);
	endtask

	task automatic select_lowest();
		int                     e0;
		logic [EXT_INT_NUM-1:0] p, m;
		e0 = err_cnt;
		write_reg(ext_addr(IER_RISE), 32'hff);
		write_reg(ext_addr(IER_FALL), 32'hff);
		write_reg(ext_addr(GER), 32'h1);
		for (int i = 0; i < 6; i++) begin
			write_reg(ext_addr(ISR), 32'hff);
			p = 8'($urandom);
			m = 8'($urandom);
			drive_pins(pins_q ^ p);
			write_reg(irq_addr(MASK), 32'(m));
			idle_cycles(2);
			expect_value("irq_o", 32'(irq_o), 32'(|(p & m)));
			read_expect(irq_addr(PEND), 32'(p & m), "PEND");
			read_expect(irq_addr(ID), id_word(p & m), "ID");
		end
		report_test("masking and selection", e0);
	endtask

	task automatic reset_mid_run();
		int e0;
		e0 = err_cnt;
		write_reg(ext_addr(IER_RISE), 32'hff);
		write_reg(irq_addr(MASK), 32'hff);
		write_reg(ext_addr(GER), 32'h1);
		drive_pins(~pins_q);
		idle_cycles(3);
		@(posedge clk);
		addr_i <= ext_addr(GER);	// read in flight, its ack rises as reset hits
		we_i   <= 1'b0;
		stb_i  <= 1'b1;
		@(posedge clk);
		stb_i     <= 1'b0;
		reset     <= 1'b1;
		ext_int_i <= '0;
		pins_q = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		expect_value("ack_o", 32'(ack_o), 32'h0);
		expect_value("irq_o", 32'(irq_o), 32'h0);
		for (int a = 0; a <= 4; a++)
			read_expect(4'(a), 32'h0, "dat_o");
		for (int a = 8; a <= 10; a++)
			read_expect(4'(a), 32'h0, "dat_o");
		report_test("reset state", e0);
	endtask

	initial begin
		reset     = 1'b1;
		addr_i    = '0;
		dat_i     = '0;
		sel_i     = '1;
		stb_i     = 1'b0;
		we_i      = 1'b0;
		ext_int_i = '0;
		pins_q    = '0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		check_register_access();
		capture_edges();
		clear_status();
		select_lowest();
		reset_mid_run();
		$display("summary: %0d ok, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish in %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule
